// ==== tb.f ====
+incdir+rtl
rtl/pma_pkg.sv
rtl/pma_cfg_regs.sv
rtl/pma_data_check.sv
rtl/pma_ifetch_check.sv
rtl/pma_fault_merge.sv
rtl/pma_checker_top.sv
bench/pma_properties.sv
bench/pma_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the PMA checker testbench with Verilator.
rm -f sim.log
verilator --binary --timing --assert -f tb.f --top-module pma_tb -o pma_sim \
  && ./obj_dir/pma_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q '^=== PASS ===$' sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== bench/pma_tb.sv ====
// PMA checker testbench.
// Directed tests over APB and both check ports, compared against a
// reference table kept by the bench. A watchdog bounds the run.
`timescale 1ns/1ps
`include "pma_params.svh"

module pma_tb;

  localparam int RESET_CYC = 12;                   // reset plus settle.
  localparam int XFER_CYC  = 5;                    // budget per apb transfer.
  localparam int T1_CYC    = 64 * XFER_CYC + 70;   // readback and requests.
  localparam int T2_CYC    = 3 * XFER_CYC + 12;
  localparam int T3_CYC    = 1 * XFER_CYC + 12;
  localparam int T4_CYC    = 2 * XFER_CYC + 12;
  localparam int T5_CYC    = 6 * XFER_CYC + 4;
  localparam int T6_CYC    = 16 * XFER_CYC + 210;
  localparam int MARGIN    = 200;
  localparam int TOTAL_CYC = RESET_CYC + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC + T6_CYC;

  logic                CLK;
  logic                rst;
  logic [31:0]         paddr;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [31:0]         pwdata;
  logic [31:0]         prdata;
  logic                pready;
  logic                pslverr;
  logic [31:0]         d_addr;
  logic                ren;
  logic                wen;
  pma_pkg::pma_width_e d_width;
  logic [31:0]         i_addr;
  logic                xen;
  pma_pkg::pma_width_e i_width;
  logic                l_fault;
  logic                s_fault;
  logic                i_fault;
  pma_pkg::pma_cause_e cause;
  logic [31:0]         fault_addr;

  logic [31:0] model_regs [`PMA_NUM_REGS];         // reference copy of the table.
  integer      seed = 32'he977;
  int          errors = 0;
  int          checks = 0;

  // request waiting for its result one cycle later.
  logic        pend_valid = 1'b0;
  string       pend_name;
  logic        pend_l, pend_s, pend_i;
  logic [1:0]  pend_cause;
  logic [31:0] pend_addr;

  pma_checker_top dut_i (.*);

  always #10 CLK = ~CLK;                           // 20 ns period.

  initial begin
    #(TOTAL_CYC * 20 + MARGIN * 20);
    $display("watchdog expired, the tests did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

  task automatic check_eq(input string tname, input string field,
                          input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("Mismatch in %s: %s expected %h, actual %h", tname, field, exp, act);
    end
  endtask

  function automatic logic addr_bad(input logic [31:0] addr);
    return (addr[1:0] != 2'b00) || (addr > 32'h0000_00ff);  // misaligned or past the table.
  endfunction

  function automatic logic [15:0] cfg_at(input logic [31:0] addr);
    logic [31:0] e;
    e = model_regs[addr[31:26]];
    return addr[25] ? e[31:16] : e[15:0];          // bit 25 picks the half.
  endfunction

  function automatic logic [31:0] region_addr(input int idx, input logic half,
                                              input logic [24:0] off);
    logic [5:0] i6;
    i6 = idx[5:0];
    return {i6, half, off};
  endfunction

  // one apb transfer through setup and access until pready.
  task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err, output int waits);
    @(posedge CLK);
    #2;
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge CLK);
    #2;
    penable = 1'b1;
    waits   = 0;
    @(negedge CLK);
    while (!pready) begin                          // counts access cycles before pready.
      waits++;
      @(negedge CLK);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge CLK);                                // write lands on this edge.
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input string tname, input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    int          waits;
    apb_xfer(1'b1, addr, data, rd, err, waits);
    check_eq(tname, "wait states", 32'd1, 32'(waits));
    check_eq(tname, "pslverr", 32'(addr_bad(addr)), 32'(err));
    if (!addr_bad(addr)) model_regs[addr[7:2]] = data;
  endtask

  task automatic apb_read(input string tname, input logic [31:0] addr);
    logic [31:0] rd;
    logic        err;
    logic [31:0] exp;
    int          waits;
    apb_xfer(1'b0, addr, 32'd0, rd, err, waits);
    exp = addr_bad(addr) ? 32'd0 : model_regs[addr[7:2]];  // error reads return zero.
    check_eq(tname, "wait states", 32'd1, 32'(waits));
    check_eq(tname, "prdata", exp, rd);
    check_eq(tname, "pslverr", 32'(addr_bad(addr)), 32'(err));
  endtask

  // drives one request, checks the previous one, then records the new one.
  task automatic send_req(input string tname, input logic [31:0] da, input logic r_en,
                          input logic w_en, input pma_pkg::pma_width_e dw,
                          input logic [31:0] ia, input logic x_en,
                          input pma_pkg::pma_width_e iw);
    logic [15:0] dc, ic;
    logic        too_wide, lf, sf, xf;
    @(posedge CLK);
    #2;
    d_addr  = da;
    ren     = r_en;
    wen     = w_en;
    d_width = dw;
    i_addr  = ia;
    xen     = x_en;
    i_width = iw;
    @(negedge CLK);
    if (pend_valid) begin
      check_eq(pend_name, "l_fault", 32'(pend_l), 32'(l_fault));
      check_eq(pend_name, "s_fault", 32'(pend_s), 32'(s_fault));
      check_eq(pend_name, "i_fault", 32'(pend_i), 32'(i_fault));
      check_eq(pend_name, "cause", 32'(pend_cause), 32'(cause));
      check_eq(pend_name, "fault_addr", pend_addr, fault_addr);
    end
    dc = cfg_at(da);
    ic = cfg_at(ia);
    too_wide = (dw > dc[4:3]);
    lf = r_en & (~dc[0] | too_wide);
    sf = ~lf & w_en & (~dc[1] | too_wide);          // a passing load already cleared width.
    xf = x_en & (~ic[2] | (iw > ic[4:3]));
    pend_valid = 1'b1;
    pend_name  = tname;
    pend_l     = lf;
    pend_s     = sf & ~lf;
    pend_i     = xf & ~lf & ~sf;                   // load over store over fetch.
    pend_cause = lf ? 2'd1 : sf ? 2'd2 : xf ? 2'd3 : 2'd0;
    pend_addr  = (lf | sf) ? da : xf ? ia : 32'd0;
  endtask

  task automatic idle_req(input string tname);
    send_req(tname, 32'd0, 1'b0, 1'b0, pma_pkg::width_byte, 32'd0, 1'b0, pma_pkg::width_byte);
  endtask

  task automatic test_reset_defaults();
    for (int i = 0; i < `PMA_NUM_REGS; i++) apb_read("reset_defaults", 32'(i * 4));
    for (int i = 0; i < `PMA_NUM_REGS; i++) begin
      send_req("reset_defaults", region_addr(i, i[0], 25'h1234), 1'b1, 1'b1,
               pma_pkg::width_word, region_addr(63 - i, ~i[0], 25'h40), 1'b1,
               pma_pkg::width_word);
    end
    idle_req("reset_defaults");
  endtask

  task automatic test_permissions();
    apb_write("permissions", 32'h0c, {16'h0017, 16'h0016});   // reg 3 lower half loses read.
    apb_write("permissions", 32'h14, {16'h0015, 16'h0017});   // reg 5 upper half loses write.
    apb_write("permissions", 32'h1c, {16'h0017, 16'h0013});   // reg 7 lower half loses execute.
    send_req("permissions", region_addr(3, 0, 25'h10), 1, 0, pma_pkg::width_word,
             region_addr(0, 0, 0), 0, pma_pkg::width_word);
    send_req("permissions", region_addr(3, 1, 25'h10), 1, 0, pma_pkg::width_word,
             region_addr(0, 0, 0), 0, pma_pkg::width_word);
    send_req("permissions", region_addr(5, 1, 25'h20), 0, 1, pma_pkg::width_half,
             region_addr(0, 0, 0), 0, pma_pkg::width_word);
    send_req("permissions", region_addr(5, 0, 25'h20), 1, 1, pma_pkg::width_word,
             region_addr(7, 0, 25'h80), 1, pma_pkg::width_word);
    send_req("permissions", region_addr(5, 1, 25'h24), 1, 1, pma_pkg::width_byte,
             region_addr(7, 1, 25'h80), 1, pma_pkg::width_word);
    send_req("permissions", region_addr(1, 0, 0), 0, 0, pma_pkg::width_word,
             region_addr(7, 0, 25'h84), 1, pma_pkg::width_half);
    idle_req("permissions");
  endtask

  task automatic test_widths();
    apb_write("widths", 32'h28, {16'h000f, 16'h0007});        // reg 10 allows half up, byte low.
    send_req("widths", region_addr(10, 0, 25'h4), 1, 0, pma_pkg::width_word,
             region_addr(0, 0, 0), 0, pma_pkg::width_byte);
    send_req("widths", region_addr(10, 0, 25'h6), 0, 1, pma_pkg::width_half,
             region_addr(0, 0, 0), 0, pma_pkg::width_byte);
    send_req("widths", region_addr(10, 1, 25'h8), 1, 1, pma_pkg::width_half,
             region_addr(10, 1, 25'hc), 1, pma_pkg::width_word);
    send_req("widths", region_addr(10, 0, 25'h9), 1, 1, pma_pkg::width_byte,
             region_addr(10, 0, 25'hc), 1, pma_pkg::width_half);
    send_req("widths", region_addr(10, 1, 25'h8), 0, 1, pma_pkg::width_dword,
             region_addr(10, 1, 25'hc), 1, pma_pkg::width_half);
    idle_req("widths");
  endtask

  task automatic test_sides();
    apb_write("sides", 32'h50, {16'h0017, 16'h0013});         // reg 20 lower half loses execute.
    apb_write("sides", 32'h54, {16'h0017, 16'h0016});         // reg 21 lower half loses read.
    send_req("sides", region_addr(21, 0, 0), 1, 1, pma_pkg::width_word,
             region_addr(20, 0, 0), 1, pma_pkg::width_word);
    send_req("sides", region_addr(20, 0, 4), 1, 0, pma_pkg::width_word,
             region_addr(20, 0, 8), 1, pma_pkg::width_word);
    send_req("sides", region_addr(22, 0, 4), 0, 1, pma_pkg::width_dword,
             region_addr(20, 0, 8), 1, pma_pkg::width_word);
    send_req("sides", region_addr(20, 0, 4), 0, 1, pma_pkg::width_word,
             region_addr(21, 0, 8), 1, pma_pkg::width_word);
    send_req("sides", region_addr(20, 1, 4), 1, 1, pma_pkg::width_word,
             region_addr(21, 1, 8), 1, pma_pkg::width_word);
    idle_req("sides");
  endtask

  task automatic test_apb_errors();
    apb_write("apb_errors", 32'h0000_0041, 32'h0000_0000);     // misaligned.
    apb_write("apb_errors", 32'h0000_0100, 32'h0000_0000);     // just past the table.
    apb_write("apb_errors", 32'h8000_0004, 32'h0000_0000);     // far out of range.
    apb_read("apb_errors", 32'h0000_0040);
    apb_read("apb_errors", 32'h0000_0000);
    apb_read("apb_errors", 32'h0000_0004);
    apb_read("apb_errors", 32'h0000_0102);
  endtask

  task automatic test_random_sweep();
    logic [31:0] a, b, c, d;
    for (int k = 0; k < 16; k++) begin
      a = $random(seed);
      b = $random(seed);
      apb_write("random_sweep", {24'd0, a[5:0], 2'b00}, b);
    end
    for (int k = 0; k < 200; k++) begin
      a = $random(seed);
      b = $random(seed);
      c = $random(seed);
      d = $random(seed);
      send_req("random_sweep", a, c[0], c[1], pma_pkg::pma_width_e'(c[3:2]),
               b, c[4], pma_pkg::pma_width_e'(d[1:0]));
    end
    idle_req("random_sweep");
  endtask

  initial begin
    CLK     = 1'b0;
    rst     = 1'b1;
    paddr   = 32'd0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = 32'd0;
    d_addr  = 32'd0;
    ren     = 1'b0;
    wen     = 1'b0;
    d_width = pma_pkg::width_byte;
    i_addr  = 32'd0;
    xen     = 1'b0;
    i_width = pma_pkg::width_byte;
    for (int i = 0; i < `PMA_NUM_REGS; i++) model_regs[i] = {2{`PMA_RESET_CFG}};
    repeat (10) @(posedge CLK);
    #2;
    rst = 1'b0;
    test_reset_defaults();
    test_permissions();
    test_widths();
    test_sides();
    test_apb_errors();
    test_random_sweep();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== bench/pma_properties.sv ====
// PMA checker properties.
// APB response timing and consistency of the merged fault outputs.
`timescale 1ns/1ps

module pma_properties (
  input logic                CLK,
  input logic                rst,
  input logic                psel,
  input logic                penable,
  input logic                pready,
  input logic                pslverr,
  input logic                l_fault,
  input logic                s_fault,
  input logic                i_fault,
  input pma_pkg::pma_cause_e cause
);

  // slave answers only in the access phase.
  a_pready_in_access: assert property (@(posedge CLK) disable iff (rst)
    pready |-> (psel && penable)) else $error("pready high outside an access phase");

  a_pslverr_in_access: assert property (@(posedge CLK) disable iff (rst)
    pslverr |-> (psel && penable)) else $error("pslverr high outside an access phase");

  // merger keeps one winner.
  a_one_fault: assert property (@(posedge CLK) disable iff (rst)
    $onehot0({l_fault, s_fault, i_fault})) else $error("more than one fault flag high");

  a_cause_none: assert property (@(posedge CLK) disable iff (rst)
    (cause == pma_pkg::cause_none) == !(l_fault || s_fault || i_fault))
    else $error("cause disagrees with the fault flags");

endmodule

bind pma_checker_top pma_properties u_properties (.*);

// ==== rtl/pma_checker_top.sv ====
// PMA checker top level.
// Region table, data and fetch checkers and the fault merger.
`timescale 1ns/1ps
`include "pma_params.svh"

module pma_checker_top (
  input  logic                 CLK,
  input  logic                 rst,
  input  logic [31:0]          paddr,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [31:0]          pwdata,
  output logic [31:0]          prdata,
  output logic                 pready,
  output logic                 pslverr,
  input  logic [31:0]          d_addr,
  input  logic                 ren,
  input  logic                 wen,
  input  pma_pkg::pma_width_e  d_width,
  input  logic [31:0]          i_addr,
  input  logic                 xen,
  input  pma_pkg::pma_width_e  i_width,
  output logic                 l_fault,
  output logic                 s_fault,
  output logic                 i_fault,
  output pma_pkg::pma_cause_e  cause,
  output logic [31:0]          fault_addr
);

  logic [`PMA_IDX_HI-`PMA_IDX_LO:0] d_idx;         // data lookup index.
  logic [`PMA_IDX_HI-`PMA_IDX_LO:0] i_idx;         // fetch lookup index.
  logic [31:0]                      d_entry;       // data region register.
  logic [31:0]                      i_entry;       // fetch region register.
  logic                             l_fault_c;     // raw load fault.
  logic                             s_fault_c;     // raw store fault.
  logic                             i_fault_c;     // raw fetch fault.

  pma_cfg_regs u_cfg_regs (
    .CLK     (CLK),
    .rst     (rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .d_idx   (d_idx),
    .d_entry (d_entry),
    .i_idx   (i_idx),
    .i_entry (i_entry)
  );

  pma_data_check u_data_check (
    .d_addr    (d_addr),
    .ren       (ren),
    .wen       (wen),
    .d_width   (d_width),
    .d_idx     (d_idx),
    .d_entry   (d_entry),
    .l_fault_c (l_fault_c),
    .s_fault_c (s_fault_c)
  );

  pma_ifetch_check u_ifetch_check (
    .i_addr    (i_addr),
    .xen       (xen),
    .i_width   (i_width),
    .i_idx     (i_idx),
    .i_entry   (i_entry),
    .i_fault_c (i_fault_c)
  );

  pma_fault_merge u_fault_merge (
    .CLK        (CLK),
    .rst        (rst),
    .l_fault_c  (l_fault_c),
    .s_fault_c  (s_fault_c),
    .i_fault_c  (i_fault_c),
    .d_addr     (d_addr),
    .i_addr     (i_addr),
    .l_fault    (l_fault),
    .s_fault    (s_fault),
    .i_fault    (i_fault),
    .cause      (cause),
    .fault_addr (fault_addr)
  );

endmodule

// ==== rtl/pma_fault_merge.sv ====
// PMA fault merger.
// Registers the three fault flags, keeps only the highest priority one
// (load, then store, then fetch) and reports its cause and address.
`timescale 1ns/1ps

module pma_fault_merge (
  input  logic                 CLK,
  input  logic                 rst,
  input  logic                 l_fault_c,
  input  logic                 s_fault_c,
  input  logic                 i_fault_c,
  input  logic [31:0]          d_addr,
  input  logic [31:0]          i_addr,
  output logic                 l_fault,
  output logic                 s_fault,
  output logic                 i_fault,
  output pma_pkg::pma_cause_e  cause,
  output logic [31:0]          fault_addr
);

  pma_pkg::pma_cause_e cause_d;                    // next cause.
  logic [31:0]         addr_d;                     // next fault address.

  // priority encode, load first.
  always_comb begin
    cause_d = pma_pkg::cause_none;
    addr_d  = 32'd0;                               // zero when nothing faults.
    if (l_fault_c) begin
      cause_d = pma_pkg::cause_load;
      addr_d  = d_addr;
    end else if (s_fault_c) begin
      cause_d = pma_pkg::cause_store;
      addr_d  = d_addr;
    end else if (i_fault_c) begin
      cause_d = pma_pkg::cause_fetch;
      addr_d  = i_addr;                            // fetch side address.
    end
  end

  // one stage, results appear the cycle after the request.
  always_ff @(posedge CLK) begin
    if (rst) begin
      l_fault    <= 1'b0;
      s_fault    <= 1'b0;
      i_fault    <= 1'b0;
      cause      <= pma_pkg::cause_none;
      fault_addr <= 32'd0;
    end else begin
      l_fault    <= (cause_d == pma_pkg::cause_load);   // losers are masked.
      s_fault    <= (cause_d == pma_pkg::cause_store);
      i_fault    <= (cause_d == pma_pkg::cause_fetch);
      cause      <= cause_d;
      fault_addr <= addr_d;
    end
  end

endmodule

// ==== rtl/pma_ifetch_check.sv ====
// PMA fetch-side checker.
// Looks up the configuration for an instruction fetch and flags a fault
// when execute is denied or the fetch is wider than allowed.
`timescale 1ns/1ps
`include "pma_params.svh"

module pma_ifetch_check (
  input  logic [31:0]                         i_addr,
  input  logic                                xen,
  input  pma_pkg::pma_width_e                 i_width,
  output logic [`PMA_IDX_HI-`PMA_IDX_LO:0]    i_idx,
  input  logic [31:0]                         i_entry,
  output logic                                i_fault_c
);

  pma_pkg::pma_cfg_t cfg;                          // selected half.

  assign i_idx = i_addr[`PMA_IDX_HI:`PMA_IDX_LO];  // own lookup, not the data one.

  always_comb begin
    if (i_addr[`PMA_HALF_BIT]) begin
      cfg = pma_pkg::pma_cfg_t'(i_entry[2*`PMA_CFG_W-1:`PMA_CFG_W]);  // upper half.
    end else begin
      cfg = pma_pkg::pma_cfg_t'(i_entry[`PMA_CFG_W-1:0]);             // lower half.
    end
  end

  // only an enabled fetch can fault.
  assign i_fault_c = xen & (~cfg.x | (i_width > cfg.acc_width));

endmodule

// ==== rtl/pma_data_check.sv ====
// PMA data-side checker.
// Looks up the configuration for a load or store and raises a single
// load or store fault for missing permission or an oversize access.
`timescale 1ns/1ps
`include "pma_params.svh"

module pma_data_check (
  input  logic [31:0]                         d_addr,
  input  logic                                ren,
  input  logic                                wen,
  input  pma_pkg::pma_width_e                 d_width,
  output logic [`PMA_IDX_HI-`PMA_IDX_LO:0]    d_idx,
  input  logic [31:0]                         d_entry,
  output logic                                l_fault_c,
  output logic                                s_fault_c
);

  pma_pkg::pma_cfg_t cfg;                          // selected half.
  logic              too_wide;                     // width over the limit.

  assign d_idx = d_addr[`PMA_IDX_HI:`PMA_IDX_LO];  // region register index.

  // bit 25 picks the configuration half.
  always_comb begin
    if (d_addr[`PMA_HALF_BIT]) begin
      cfg = pma_pkg::pma_cfg_t'(d_entry[2*`PMA_CFG_W-1:`PMA_CFG_W]);  // upper half.
    end else begin
      cfg = pma_pkg::pma_cfg_t'(d_entry[`PMA_CFG_W-1:0]);             // lower half.
    end
  end

  assign too_wide = (d_width > cfg.acc_width);     // enum order follows size.

  // read wins, so at most one flag is set.
  always_comb begin
    l_fault_c = 1'b0;
    s_fault_c = 1'b0;
    if (ren) begin
      l_fault_c = ~cfg.r | too_wide;               // denied or oversize load.
      s_fault_c = wen & cfg.r & ~too_wide & ~cfg.w;  // load ok, write still denied.
    end else if (wen) begin
      s_fault_c = ~cfg.w | too_wide;               // denied or oversize store.
    end
  end

endmodule

// ==== rtl/pma_cfg_regs.sv ====
// PMA region table.
// 64 registers of two configurations each, programmed over APB with
// one wait state, plus two combinational lookup ports for the checkers.
`timescale 1ns/1ps
`include "pma_params.svh"

module pma_cfg_regs (
  input  logic                                CLK,
  input  logic                                rst,
  input  logic [31:0]                         paddr,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [31:0]                         pwdata,
  output logic [31:0]                         prdata,
  output logic                                pready,
  output logic                                pslverr,
  input  logic [`PMA_IDX_HI-`PMA_IDX_LO:0]    d_idx,
  output logic [31:0]                         d_entry,
  input  logic [`PMA_IDX_HI-`PMA_IDX_LO:0]    i_idx,
  output logic [31:0]                         i_entry
);

  logic [31:0] regs [`PMA_NUM_REGS];               // region table.
  logic        wait_q;                             // first access cycle seen.
  logic        access;                             // apb access phase.
  logic        addr_err;                           // bad apb address.
  logic [`PMA_APB_IDX_HI-`PMA_APB_IDX_LO:0] apb_idx;  // register picked by paddr.

  assign access   = psel & penable;
  assign apb_idx  = paddr[`PMA_APB_IDX_HI:`PMA_APB_IDX_LO];
  assign addr_err = (|paddr[1:0]) | (|paddr[31:`PMA_APB_RANGE_LO]);  // misaligned or past 0xff.

  // the flag marks the wait cycle, so the slave answers one cycle later.
  always_ff @(posedge CLK) begin
    if (rst) begin
      wait_q <= 1'b0;
    end else begin
      wait_q <= access & ~wait_q;                  // drops again after the answer.
    end
  end

  assign pready  = access & wait_q;                // second access cycle.
  assign pslverr = pready & addr_err;              // error reported with pready.

  // read data is valid while the slave answers, zero on error.
  always_comb begin
    prdata = 32'd0;
    if (pready && !pwrite && !addr_err) begin
      prdata = regs[apb_idx];
    end
  end

  // table writes land at the end of the answering cycle.
  always_ff @(posedge CLK) begin
    if (rst) begin
      for (int i = 0; i < `PMA_NUM_REGS; i++) begin
        regs[i] <= {2{`PMA_RESET_CFG}};            // both halves permissive.
      end
    end else if (pready && pwrite && !addr_err) begin
      regs[apb_idx] <= pwdata;                     // errored writes are dropped.
    end
  end

  // lookup ports, no clock in the path.
  assign d_entry = regs[d_idx];                    // data side.
  assign i_entry = regs[i_idx];                    // fetch side.

endmodule

// ==== rtl/pma_pkg.sv ====
// PMA checker types.
// Access width and fault cause encodings, and the configuration layout.
package pma_pkg;

  // ordered so that a wider access compares greater.
  typedef enum logic [1:0] {
    width_byte  = 2'd0,       // 8 bit.
    width_half  = 2'd1,       // 16 bit.
    width_word  = 2'd2,       // 32 bit.
    width_dword = 2'd3        // 64 bit.
  } pma_width_e;

  // reported cause, one per merged fault.
  typedef enum logic [1:0] {
    cause_none  = 2'd0,       // nothing to report.
    cause_load  = 2'd1,       // read denied or too wide.
    cause_store = 2'd2,       // write denied or too wide.
    cause_fetch = 2'd3        // execute denied or too wide.
  } pma_cause_e;

  // one 16-bit half of a region register, r in bit 0.
  typedef struct packed {
    logic [10:0] reserved;    // bits 15:5, stored but ignored.
    pma_width_e  acc_width;   // bits 4:3, widest access allowed.
    logic        x;           // bit 2, execute allowed.
    logic        w;           // bit 1, write allowed.
    logic        r;           // bit 0, read allowed.
  } pma_cfg_t;

endpackage

// ==== rtl/pma_params.svh ====
// PMA checker constants.
// Table depth, address field positions and the reset configuration.
`ifndef PMA_PARAMS_SVH
`define PMA_PARAMS_SVH

`define PMA_NUM_REGS      64        // region registers in the table.
`define PMA_IDX_HI        31        // top address bit of the region index.
`define PMA_IDX_LO        26        // bottom address bit of the region index.
`define PMA_HALF_BIT      25        // picks the upper or lower configuration.
`define PMA_CFG_W         16        // bits per configuration half.

`define PMA_APB_IDX_HI    7         // apb register select, top bit.
`define PMA_APB_IDX_LO    2         // apb register select, bottom bit.
`define PMA_APB_RANGE_LO  8         // any set bit from here up is out of range.

// r, w, x set and word access width.
`define PMA_RESET_CFG     16'h0017

`endif
